//--- tb.f
verilog/spi_bus_pkg.sv
verilog/spi_pkg.sv
verilog/spi_regs.sv
verilog/spi_engine.sv
verilog/spi_periph.sv
verif/spi_engine_props.sv
verif/spi_checker.sv
verif/spi_tb.sv

//--- verif/spi_tb.sv
module spi_tb;

    logic                  seq;
    logic                  rst_n;
    spi_bus_pkg::apb_req_t apb_req;
    spi_bus_pkg::apb_rsp_t apb_rsp;
    logic                  irq;
    logic                  sclk;
    logic                  mosi;
    logic                  ss_n;
    logic                  miso;

    logic [31:0] rng = 32'hffc4_7c34;
    logic [31:0] slave_word = '0;  // Slave model settings
    int          slave_len = 8;
    bit          slave_lsb = 0;
    logic        slave_cpol = 0;
    logic        slave_cpha = 0;
    int          shifts = 0;
    logic        slave_prev_sclk = 0;

    spi_periph i_spi_periph (
        .seq     (seq),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq     (irq),
        .sclk    (sclk),
        .mosi    (mosi),
        .ss_n    (ss_n),
        .miso    (miso)
    );

    spi_checker i_checker (
        .seq   (seq),
        .rst_n (rst_n),
        .sclk  (sclk),
        .mosi  (mosi),
        .ss_n  (ss_n)
    );

    initial begin
        seq = 1'b0;
        forever #2 seq = ~seq;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic slave_bit(int idx);
        if (idx >= slave_len) begin
            return 1'b0;
        end
        return slave_lsb ? slave_word[idx] : slave_word[slave_len-1-idx];
    endfunction

    // SPI slave, advances on shift edges; cpha=1 spends its first shift edge on bit 0
    always @(posedge seq) begin
        if (ss_n) begin
            shifts = 0;
        end else if (sclk !== slave_prev_sclk && sclk === (slave_cpol ^ slave_cpha)) begin
            shifts++;
        end
        slave_prev_sclk = sclk;
        #1 miso = slave_bit((shifts > slave_cpha) ? shifts - slave_cpha : 0);
    end

    task automatic apb_xfer(int idx, bit write, logic [31:0] wdata, logic [3:0] strb,
                            output logic [31:0] rdata, output logic err);
        int n;
        n = 0;
        @(posedge seq);
        #1;
        apb_req.paddr   = idx << 2;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = strb;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge seq);
        #1 apb_req.penable = 1'b1;
        rdata = '0;
        err   = 1'b1;
        while (n < 2000) begin
            @(posedge seq);
            if (apb_rsp.pready) begin
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
                n     = 2001;
            end else begin
                n++;
            end
        end
        if (n == 2000) begin
            i_checker.note_failure($sformatf("APB access to word %0d never got pready", idx));
        end
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic reg_write(int idx, logic [31:0] data, logic [3:0] strb, output logic err);
        logic [31:0] unused;
        apb_xfer(idx, 1'b1, data, strb, unused, err);
    endtask

    task automatic reg_read(int idx, output logic [31:0] data, output logic err);
        apb_xfer(idx, 1'b0, '0, 4'hf, data, err);
    endtask

    // Polls SR until the given status bit is set
    task automatic wait_status(int bit_pos, string what);
        logic [31:0] sr;
        logic        err;
        int          n;
        n  = 0;
        sr = '0;
        while (!sr[bit_pos] && n < 500) begin
            reg_read(spi_pkg::reg_sr, sr, err);
            n++;
        end
        if (!sr[bit_pos]) begin
            i_checker.note_failure($sformatf("timed out waiting for %s in SR", what));
        end
    endtask

    task automatic read_dr(string name, logic [31:0] word, int len, bit lsb);
        logic [31:0] data;
        logic        err;
        wait_status(1, "rx_full");
        reg_read(spi_pkg::reg_dr, data, err);
        i_checker.check_eq({name, " dr read err"}, 0, err);
        i_checker.check_rx({name, " rx"}, word, len, lsb, data);
    endtask

    task automatic run_frame(logic cpol, logic cpha, bit lsb, int len);
        string       name;
        logic [31:0] word;
        logic [31:0] data;
        logic        err;
        name = $sformatf("cpol%0d cpha%0d lsb%0d len%0d", cpol, cpha, lsb, len);
        reg_write(spi_pkg::reg_cr, 32'h7 | (cpha << 4) | (cpol << 5) | (lsb << 6) | (len << 8),
                  4'hf, err);
        word       = next_rand();
        slave_word = next_rand();
        slave_len  = len;
        slave_lsb  = lsb;
        slave_cpol = cpol;
        slave_cpha = cpha;
        i_checker.set_mode(cpol, cpha);
        i_checker.push_frame(name, word, len, lsb);
        reg_write(spi_pkg::reg_dr, word, 4'hf, err);
        i_checker.check_eq({name, " dr write err"}, 0, err);
        read_dr(name, slave_word, len, lsb);
        i_checker.check_eq({name, " sclk idle"}, cpol, sclk);
        reg_read(spi_pkg::reg_sr, data, err);
        i_checker.check_eq({name, " rx_full after read"}, 0, data[1]);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] w1;
        logic [31:0] w2;
        logic        err;
        int          lens[4];
        lens    = '{1, 8, 17, 32};
        apb_req = '0;
        miso    = 1'b0;
        rst_n   = 1'b0;
        repeat (16) @(posedge seq);
        #1 rst_n = 1'b1;

        reg_read(spi_pkg::reg_cr, data, err);
        i_checker.check_eq("reset cr", 0, data);
        reg_read(spi_pkg::reg_sr, data, err);
        i_checker.check_eq("reset sr", 1, data);
        reg_read(spi_pkg::reg_brr, data, err);
        i_checker.check_eq("reset brr", 0, data);
        reg_read(spi_pkg::reg_ier, data, err);
        i_checker.check_eq("reset ier", 0, data);
        i_checker.check_eq("reset irq", 0, irq);

        reg_write(spi_pkg::reg_brr, 32'd2, 4'hf, err); // Slow enough for the slave model
        for (int m = 0; m < 4; m++) begin
            for (int l = 0; l < 2; l++) begin
                foreach (lens[k]) begin
                    run_frame(m[1], m[0], l[0], lens[k]);
                end
            end
        end

        // Error responses; engine stays busy with w1 so w2 fills the buffer
        reg_write(spi_pkg::reg_cr, 32'h807, 4'hf, err);
        i_checker.set_mode(0, 0);
        slave_cpol = 0;
        slave_cpha = 0;
        slave_lsb  = 0;
        slave_len  = 8;
        w1 = next_rand();
        w2 = next_rand();
        i_checker.push_frame("buffer full w1", w1, 8, 0);
        i_checker.push_frame("buffer full w2", w2, 8, 0);
        reg_write(spi_pkg::reg_dr, w1, 4'hf, err);
        reg_write(spi_pkg::reg_dr, w2, 4'hf, err);
        reg_write(spi_pkg::reg_dr, next_rand(), 4'hf, err);
        i_checker.check_eq("dr write full err", 1, err);
        reg_read(spi_pkg::reg_sr, data, err);
        i_checker.check_eq("sr after full write", 0, data[0]);
        read_dr("buffer full w1", slave_word, 8, 0);
        read_dr("buffer full w2", slave_word, 8, 0);

        reg_write(spi_pkg::reg_cr, 32'h805, 4'hf, err);
        reg_write(spi_pkg::reg_dr, next_rand(), 4'hf, err);
        i_checker.check_eq("dr write tx_en clear err", 1, err);
        reg_read(spi_pkg::reg_sr, data, err);
        i_checker.check_eq("sr after tx_en clear", 1, data);
        reg_read(spi_pkg::reg_dr, data, err);
        i_checker.check_eq("dr read empty err", 1, err);
        reg_write(spi_pkg::reg_sr, 32'hffff_ffff, 4'hf, err);
        i_checker.check_eq("sr write err", 1, err);
        reg_read(spi_pkg::reg_sr, data, err);
        i_checker.check_eq("sr after write", 1, data);
        reg_write(7, 32'hffff_ffff, 4'hf, err);
        i_checker.check_eq("address 7 err", 1, err);
        reg_read(spi_pkg::reg_cr, data, err);
        i_checker.check_eq("cr after errors", 32'h805, data);

        // Byte strobes
        reg_write(spi_pkg::reg_brr, 32'h1122_3344, 4'hf, err);
        reg_write(spi_pkg::reg_brr, 32'haabb_ccdd, 4'b0101, err);
        reg_read(spi_pkg::reg_brr, data, err);
        i_checker.check_eq("brr strobe", 32'h11bb_33dd, data);
        reg_write(spi_pkg::reg_ier, 32'h1122_3344, 4'hf, err);
        reg_write(spi_pkg::reg_ier, 32'haabb_ccdd, 4'b1010, err);
        reg_read(spi_pkg::reg_ier, data, err);
        i_checker.check_eq("ier strobe", 32'haa22_cc44, data);
        reg_write(spi_pkg::reg_ier, 32'h0, 4'hf, err);
        reg_write(spi_pkg::reg_brr, 32'd2, 4'hf, err);

        // Interrupts
        reg_write(spi_pkg::reg_cr, 32'h807, 4'hf, err);
        reg_write(spi_pkg::reg_ier, 32'h1, 4'hf, err);
        i_checker.check_eq("irq tx_empty", 1, irq);
        w1 = next_rand();
        w2 = next_rand();
        i_checker.push_frame("irq w1", w1, 8, 0);
        i_checker.push_frame("irq w2", w2, 8, 0);
        reg_write(spi_pkg::reg_dr, w1, 4'hf, err);
        reg_write(spi_pkg::reg_dr, w2, 4'hf, err);
        i_checker.check_eq("irq with tx buffer full", 0, irq);
        wait_status(0, "tx_empty");
        i_checker.check_eq("irq after tx sent", 1, irq);
        reg_write(spi_pkg::reg_ier, 32'h2, 4'hf, err);
        read_dr("irq w1", slave_word, 8, 0);
        wait_status(1, "rx_full");
        i_checker.check_eq("irq rx_full", 1, irq);
        read_dr("irq w2", slave_word, 8, 0);
        i_checker.check_eq("irq after dr read", 0, irq);

        repeat (4) @(posedge seq);
        i_checker.check_frames_done();
        $display("Checks: %0d, errors: %0d", i_checker.checks, i_checker.errors);
        if (i_checker.errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verif/spi_checker.sv
module spi_checker (
    input logic seq,
    input logic rst_n,
    input logic sclk,
    input logic mosi,
    input logic ss_n
);

    int          errors = 0;
    int          checks = 0;
    logic [31:0] exp_word_q[$];
    int          exp_len_q[$];
    bit          exp_lsb_q[$];
    string       exp_name_q[$];
    logic        cpol = 1'b0;
    logic        cpha = 1'b0;
    logic [31:0] got = '0;
    int          nbits = 0;
    logic        prev_sclk = 1'b0;
    logic        prev_ss = 1'b1;

    // Bit i is the i-th bit on mosi
    function automatic logic [31:0] expected_bits(logic [31:0] word, int len, bit lsb_first);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < len; i++) begin
            r[i] = lsb_first ? word[i] : word[len-1-i];
        end
        return r;
    endfunction

    // Slave sends in the same order, the master right-aligns
    function automatic logic [31:0] expected_rx(logic [31:0] slave_word, int len, bit lsb_first);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < len; i++) begin
            b = lsb_first ? slave_word[i] : slave_word[len-1-i];
            r[lsb_first ? i : len-1-i] = b;
        end
        return r;
    endfunction

    task automatic set_mode(logic new_cpol, logic new_cpha);
        cpol = new_cpol;
        cpha = new_cpha;
    endtask

    task automatic push_frame(string name, logic [31:0] word, int len, bit lsb_first);
        exp_name_q.push_back(name);
        exp_word_q.push_back(word);
        exp_len_q.push_back(len);
        exp_lsb_q.push_back(lsb_first);
    endtask

    task automatic note_failure(string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic check_eq(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_rx(string name, logic [31:0] slave_word, int len, bit lsb_first,
                            logic [31:0] actual);
        check_eq(name, expected_rx(slave_word, len, lsb_first), actual);
    endtask

    // Frames still queued never showed up on the pins
    task automatic check_frames_done();
        if (exp_word_q.size() != 0) begin
            note_failure($sformatf("%0d expected frames never appeared on the pins",
                                   exp_word_q.size()));
        end
    endtask

    task automatic compare_frame();
        string name;
        int    len;
        if (exp_word_q.size() == 0) begin
            note_failure("a frame appeared on the pins while none was expected");
        end else begin
            name = exp_name_q.pop_front();
            len  = exp_len_q.pop_front();
            check_eq({name, " mosi"}, expected_bits(exp_word_q.pop_front(), len,
                     exp_lsb_q.pop_front()), got);
            check_eq({name, " bit count"}, len, nbits);
        end
        got   = '0;
        nbits = 0;
    endtask

    // Pin values seen at the clock edge, before the DUT updates
    always @(posedge seq) begin
        if (!rst_n) begin
            got   = '0;
            nbits = 0;
        end else if (!ss_n) begin
            if (sclk !== prev_sclk && sclk === ~(cpol ^ cpha)) begin // Sample edge
                if (nbits < 32) begin
                    got[nbits] = mosi;
                end
                nbits++;
            end
        end else if (!prev_ss) begin
            compare_frame();
        end
        prev_sclk = sclk;
        prev_ss   = ss_n;
    end

endmodule

//--- verif/spi_engine_props.sv
module spi_engine_props (
    input logic                   seq,
    input logic                   rst_n,
    input spi_pkg::engine_state_t state,
    input spi_pkg::spi_cfg_t      cfg_q,
    input logic                   ss_n,
    input logic                   sclk_q,
    input logic                   rx_valid
);

    // Slave select only drops inside a frame
    ss_high_in_idle: assert property (@(posedge seq) disable iff (!rst_n)
        (state == spi_pkg::idle) |-> ss_n)
        else $error("ss_n low while the engine is idle");

    // Every frame hands the clock back at its idle level
    sclk_idle_level: assert property (@(posedge seq) disable iff (!rst_n)
        (state == spi_pkg::idle) |-> (sclk_q == cfg_q.cpol))
        else $error("sclk not back at cpol when the engine went idle");

    // A waiting rx word blocks the next frame
    no_frame_while_rx_waits: assert property (@(posedge seq) disable iff (!rst_n)
        rx_valid |=> (state == spi_pkg::idle))
        else $error("engine started a frame while rx_valid waits");

endmodule

bind spi_engine spi_engine_props i_spi_engine_props (
    .seq      (seq),
    .rst_n    (rst_n),
    .state    (state),
    .cfg_q    (cfg_q),
    .ss_n     (ss_n),
    .sclk_q   (sclk_q),
    .rx_valid (rx_valid)
);

//--- verilog/spi_periph.sv
module spi_periph (
    input  logic                  seq,
    input  logic                  rst_n,
    input  spi_bus_pkg::apb_req_t apb_req,
    output spi_bus_pkg::apb_rsp_t apb_rsp,
    output logic                  irq,
    output logic                  sclk,
    output logic                  mosi,
    output logic                  ss_n,
    input  logic                  miso
);

    // Transmit stream, regs to engine
    logic                               tx_valid;
    logic                               tx_ready;
    logic [spi_bus_pkg::data_width-1:0] tx_data;

    // Receive stream, engine to regs
    logic                               rx_valid;
    logic                               rx_ready;
    logic [spi_bus_pkg::data_width-1:0] rx_data;

    spi_pkg::spi_cfg_t cfg;
    logic              busy;

    spi_regs i_spi_regs (
        .seq      (seq),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .irq      (irq),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_data  (rx_data),
        .cfg      (cfg),
        .busy     (busy)
    );

    spi_engine i_spi_engine (
        .seq      (seq),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_data  (rx_data),
        .busy     (busy),
        .sclk     (sclk),
        .mosi     (mosi),
        .ss_n     (ss_n),
        .miso     (miso)
    );

endmodule

//--- verilog/spi_engine.sv
module spi_engine (
    input  logic                                seq,
    input  logic                                rst_n,
    input  spi_pkg::spi_cfg_t                   cfg,
    input  logic                                tx_valid,
    output logic                                tx_ready,
    input  logic [spi_bus_pkg::data_width-1:0]  tx_data,
    output logic                                rx_valid,
    input  logic                                rx_ready,
    output logic [spi_bus_pkg::data_width-1:0]  rx_data,
    output logic                                busy,
    output logic                                sclk,
    output logic                                mosi,
    output logic                                ss_n,
    input  logic                                miso
);

    spi_pkg::engine_state_t             state;
    spi_pkg::spi_cfg_t                  cfg_q;     // Frozen for the frame
    logic [15:0]                        cnt;
    logic                               tick;
    logic [6:0]                         half;      // Half-bit index in shift
    logic [6:0]                         last_half;
    logic                               last;
    logic [spi_bus_pkg::data_width-1:0] tx_sr;
    logic [spi_bus_pkg::data_width-1:0] rx_sr;
    logic                               sclk_q;

    assign tick      = (state != spi_pkg::idle) && (cnt == cfg_q.baud_div);
    assign last_half = {cfg_q.frame_len, 1'b0} - 7'd1;
    assign last      = (half == last_half);

    assign tx_ready = (state == spi_pkg::idle) && !rx_valid; // Hold off while rx word waits
    assign busy     = (state != spi_pkg::idle);

    // Idle level follows the live setting
    assign sclk = (state == spi_pkg::idle) ? cfg.cpol : sclk_q;
    assign mosi = cfg_q.lsb_first ? tx_sr[0] : tx_sr[spi_bus_pkg::data_width-1];

    // LSB-first bits enter from the top, so move them down
    assign rx_data = cfg_q.lsb_first ? rx_sr >> (6'd32 - cfg_q.frame_len) : rx_sr;

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state    <= spi_pkg::idle;
            cfg_q    <= '0;
            cnt      <= '0;
            half     <= '0;
            tx_sr    <= '0;
            rx_sr    <= '0;
            sclk_q   <= 1'b0;
            ss_n     <= 1'b1;
            rx_valid <= 1'b0;
        end else begin
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end

            // Half period is baud_div+1 cycles
            if (state == spi_pkg::idle || tick) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 16'd1;
            end

            case (state)
                spi_pkg::idle: begin
                    if (tx_valid && tx_ready) begin
                        cfg_q  <= cfg;
                        sclk_q <= cfg.cpol;
                        rx_sr  <= '0;
                        half   <= '0;
                        ss_n   <= 1'b0;
                        state  <= spi_pkg::lead;
                        if (cfg.lsb_first) begin
                            tx_sr <= tx_data;
                        end else begin
                            tx_sr <= tx_data << (6'd32 - cfg.frame_len); // MSB to top
                        end
                    end
                end
                spi_pkg::lead: begin
                    if (tick) begin
                        if (cfg_q.cpha) begin
                            sclk_q <= ~sclk_q; // Shift edge of bit 0
                        end
                        state <= spi_pkg::shift;
                    end
                end
                spi_pkg::shift: begin
                    if (tick) begin
                        half <= half + 7'd1;
                        // cpha=1 has already spent one edge in lead
                        if (!cfg_q.cpha || !last) begin
                            sclk_q <= ~sclk_q;
                        end
                        if (!half[0]) begin // Mid-bit sample
                            if (cfg_q.lsb_first) begin
                                rx_sr <= {miso, rx_sr[spi_bus_pkg::data_width-1:1]};
                            end else begin
                                rx_sr <= {rx_sr[spi_bus_pkg::data_width-2:0], miso};
                            end
                        end else if (!last) begin
                            tx_sr <= cfg_q.lsb_first ? tx_sr >> 1 : tx_sr << 1;
                        end
                        if (last) begin
                            state <= spi_pkg::trail;
                        end
                    end
                end
                spi_pkg::trail: begin
                    if (tick) begin
                        ss_n     <= 1'b1;
                        rx_valid <= 1'b1;
                        state    <= spi_pkg::idle;
                    end
                end
                default: state <= spi_pkg::idle;
            endcase
        end
    end

endmodule

//--- verilog/spi_regs.sv
module spi_regs (
    input  logic                                seq,
    input  logic                                rst_n,
    input  spi_bus_pkg::apb_req_t               apb_req,
    output spi_bus_pkg::apb_rsp_t               apb_rsp,
    output logic                                irq,
    output logic                                tx_valid,
    input  logic                                tx_ready,
    output logic [spi_bus_pkg::data_width-1:0]  tx_data,
    input  logic                                rx_valid,
    output logic                                rx_ready,
    input  logic [spi_bus_pkg::data_width-1:0]  rx_data,
    output spi_pkg::spi_cfg_t                   cfg,
    input  logic                                busy
);

    spi_pkg::spi_ctrl_t                 ctrl;
    spi_pkg::spi_ctrl_t                 ctrl_next;  // CR after strobe merge
    spi_pkg::spi_stat_t                 stat;
    logic [spi_bus_pkg::data_width-1:0] brr;
    logic [spi_bus_pkg::data_width-1:0] ier;
    logic [spi_bus_pkg::data_width-1:0] tx_buf;
    logic [spi_bus_pkg::data_width-1:0] rx_buf;
    logic [spi_bus_pkg::data_width-1:0] mask;
    logic [spi_pkg::idx_width-1:0]      index;
    logic                               tx_empty;
    logic                               rx_full;
    logic                               pending;
    logic                               finish;
    logic                               cfg_stall;

    // Engine view of a control word, frame length clamped to 1..32
    function automatic spi_pkg::spi_cfg_t make_cfg(spi_pkg::spi_ctrl_t c,
                                                   logic [15:0] div);
        spi_pkg::spi_cfg_t r;
        r.cpha      = c.cpha;
        r.cpol      = c.cpol;
        r.lsb_first = c.lsb_first;
        r.baud_div  = div;
        if (c.frame_len == 8'd0 || c.frame_len > 8'd32) begin
            r.frame_len = 6'd32;
        end else begin
            r.frame_len = c.frame_len[5:0];
        end
        return r;
    endfunction

    assign index   = apb_req.paddr[spi_bus_pkg::addr_width-1 -: spi_pkg::idx_width];
    assign pending = apb_req.psel && !apb_rsp.pready;                  // New access
    assign finish  = apb_req.psel && apb_req.penable && apb_rsp.pready; // Handshake done

    always_comb begin
        for (int i = 0; i < spi_bus_pkg::strb_width; i++) begin
            mask[i*8 +: 8] = apb_req.pstrb[i] ? 8'hff : 8'h00;
        end
        ctrl_next = (apb_req.pwdata & mask) | (ctrl & ~mask);

        stat          = '0;
        stat.tx_empty = tx_empty;
        stat.rx_full  = rx_full;

        cfg = make_cfg(ctrl, brr[15:0]);

        // Settings may only move while the engine sits idle
        cfg_stall = busy && (make_cfg(ctrl_next, brr[15:0]) != cfg);

        irq = ctrl.enable && (
            (tx_empty && ier[spi_pkg::ier_tx_empty] && ctrl.tx_en) ||
            (rx_full  && ier[spi_pkg::ier_rx_full]  && ctrl.rx_en));
    end

    assign tx_valid = !tx_empty;
    assign tx_data  = tx_buf;
    assign rx_ready = !rx_full;

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            ctrl     <= '0;
            brr      <= '0;
            ier      <= '0;
            tx_buf   <= '0;
            rx_buf   <= '0;
            tx_empty <= 1'b1;
            rx_full  <= 1'b0;
            apb_rsp  <= '0;
        end else begin
            if (pending) begin
                case (index)
                    spi_pkg::reg_dr: begin
                        apb_rsp.pready <= 1'b1;
                        if (apb_req.pwrite) begin
                            if (ctrl.enable && ctrl.tx_en && tx_empty) begin
                                tx_buf   <= apb_req.pwdata;
                                tx_empty <= 1'b0;
                            end else begin
                                apb_rsp.pslverr <= 1'b1;
                            end
                        end else if (ctrl.enable && ctrl.rx_en && rx_full) begin
                            apb_rsp.prdata <= rx_buf;
                            rx_full        <= 1'b0;
                        end else begin
                            apb_rsp.pslverr <= 1'b1;
                        end
                    end
                    spi_pkg::reg_cr: begin
                        if (!apb_req.pwrite) begin
                            apb_rsp.prdata <= ctrl;
                            apb_rsp.pready <= 1'b1;
                        end else if (!cfg_stall) begin // else retry next cycle
                            ctrl           <= ctrl_next;
                            apb_rsp.pready <= 1'b1;
                        end
                    end
                    spi_pkg::reg_sr: begin
                        apb_rsp.pready <= 1'b1;
                        if (apb_req.pwrite) begin
                            apb_rsp.pslverr <= 1'b1;
                        end else begin
                            apb_rsp.prdata <= stat;
                        end
                    end
                    spi_pkg::reg_brr: begin
                        apb_rsp.pready <= 1'b1;
                        if (apb_req.pwrite) begin
                            brr <= (apb_req.pwdata & mask) | (brr & ~mask);
                        end else begin
                            apb_rsp.prdata <= brr;
                        end
                    end
                    spi_pkg::reg_ier: begin
                        apb_rsp.pready <= 1'b1;
                        if (apb_req.pwrite) begin
                            ier <= (apb_req.pwdata & mask) | (ier & ~mask);
                        end else begin
                            apb_rsp.prdata <= ier;
                        end
                    end
                    default: begin // Hole in the map
                        apb_rsp.pready  <= 1'b1;
                        apb_rsp.pslverr <= 1'b1;
                    end
                endcase
            end else if (finish) begin
                apb_rsp <= '0;
            end

            // Stream handshakes never collide with the APB updates above
            if (tx_valid && tx_ready) begin
                tx_empty <= 1'b1;
            end
            if (rx_valid && rx_ready) begin
                rx_buf  <= rx_data;
                rx_full <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/spi_pkg.sv
package spi_pkg;

    // Word index taken from paddr above the byte lanes
    localparam int idx_width = spi_bus_pkg::addr_width - $clog2(spi_bus_pkg::strb_width);

    localparam logic [idx_width-1:0] reg_dr  = 'd0; // Data
    localparam logic [idx_width-1:0] reg_cr  = 'd1; // Control
    localparam logic [idx_width-1:0] reg_sr  = 'd2; // Status, read only
    localparam logic [idx_width-1:0] reg_brr = 'd3; // Baud rate
    localparam logic [idx_width-1:0] reg_ier = 'd4; // Interrupt enable

    // IER bit positions
    localparam int ier_tx_empty = 0;
    localparam int ier_rx_full  = 1;

    typedef struct packed {
        logic [15:0] rsvd_31_16;
        logic [7:0]  frame_len;  // 0 or above 32 means 32
        logic        rsvd_7;
        logic        lsb_first;
        logic        cpol;
        logic        cpha;
        logic        rsvd_3;
        logic        rx_en;
        logic        tx_en;
        logic        enable;
    } spi_ctrl_t;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        rx_full;
        logic        tx_empty;
    } spi_stat_t;

    // What the engine latches per frame
    typedef struct packed {
        logic        cpha;
        logic        cpol;
        logic        lsb_first;
        logic [5:0]  frame_len; // 1..32
        logic [15:0] baud_div;
    } spi_cfg_t;

    typedef enum logic [1:0] {
        idle,
        lead,
        shift,
        trail
    } engine_state_t;

endpackage

//--- verilog/spi_bus_pkg.sv
package spi_bus_pkg;

    // Bus geometry
    localparam int addr_width = 12;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // Master to slave, about 51 bits
    typedef struct packed {
        logic [addr_width-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [data_width-1:0] pwdata;
        logic [strb_width-1:0] pstrb;
    } apb_req_t;

    // Slave to master, 34 bits
    typedef struct packed {
        logic [data_width-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage
